//--- Makefile
SIM      := verilator
FLAGS    := --binary --assert --timescale 1ns/1ns -j 0
TOP      := tb_trace_render
FILELIST := trace_render.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/bcd_converter.sv
`timescale 1ns/1ns

module bcd_converter (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                start,
	input  logic [trace_pkg::NUM_WIDTH-1:0]     value,
	output logic                                done,
	output logic [4*trace_pkg::NUM_DIGITS-1:0]  digits
);
	import trace_pkg::*;

	localparam int CNT_W = $clog2(NUM_WIDTH);

	logic [NUM_WIDTH-1:0]    shift_q;
	logic [4*NUM_DIGITS-1:0] bcd_q;
	logic [4*NUM_DIGITS-1:0] bcd_adj;
	logic [CNT_W-1:0]        iter_q;
	logic                    busy_q;

	// Add 3 to every digit of 5 or more before the shift
	always_comb begin
		bcd_adj = bcd_q;
		for (int d = 0; d < NUM_DIGITS; d++) begin
			if (bcd_q[4*d +: 4] >= 4'd5)
				bcd_adj[4*d +: 4] = bcd_q[4*d +: 4] + 4'd3;
		end
	end

	// start already shifts in the first bit, so done lands after NUM_WIDTH cycles
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			iter_q <= '0;
			done   <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy_q <= 1'b1;
				iter_q <= CNT_W'(1);
			end else if (busy_q) begin
				iter_q <= iter_q + 1'b1;
				if (iter_q == CNT_W'(NUM_WIDTH - 1)) begin
					busy_q <= 1'b0;
					done   <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			bcd_q   <= {{(4*NUM_DIGITS-1){1'b0}}, value[NUM_WIDTH-1]};
			shift_q <= {value[NUM_WIDTH-2:0], 1'b0};
		end else if (busy_q) begin
			{bcd_q, shift_q} <= {bcd_adj[4*NUM_DIGITS-2:0], shift_q, 1'b0};
		end
	end

	assign digits = bcd_q;

endmodule

//--- design/credit_counter.sv
`timescale 1ns/1ns

module credit_counter #(
	parameter int OUT_CREDITS = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  logic grant,
	input  logic spend,
	output logic available
);
	localparam int CNT_W = $clog2(OUT_CREDITS + 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= CNT_W'(OUT_CREDITS);
		end else begin
			case ({grant, spend})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				// Grant and spend together cancel out
				default: count <= count;
			endcase
		end
	end

	assign available = (count != '0);

	// Sink never over-grants and the FSM never spends without a credit
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		(count <= CNT_W'(OUT_CREDITS)) && !(spend && count == '0));

endmodule

//--- design/issue_decoder.sv
`timescale 1ns/1ns

module issue_decoder (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                issue_valid,
	input  trace_pkg::issue_t   issue,
	output logic                dec_valid,
	output trace_pkg::decoded_t dec
);
	import trace_pkg::*;

	logic [5:0] opcode;
	logic [5:0] op_masked;
	logic [5:0] funct;
	logic       scalar;
	logic [2:0] warp_bin;
	inst_e      inst;
	fmt_e       fmt;

	assign opcode    = issue.instr[31:26];
	assign scalar    = opcode[4];
	assign op_masked = {opcode[5], 1'b0, opcode[3:0]};
	assign funct     = issue.instr[5:0];

	// One-hot warp ID to binary index
	always_comb begin
		warp_bin = '0;
		for (int i = 0; i < 8; i++) begin
			if (issue.warp_onehot[i])
				warp_bin = warp_bin | 3'(i);
		end
	end

	////////////////////////////////////////////////////////////
	// Classification
	////////////////////////////////////////////////////////////

	always_comb begin
		inst = UNKNOWN;
		case (op_masked)
			OPC_RTYPE: begin
				case (funct)
					FN_ADD:  inst = ADD;
					FN_SUB:  inst = SUB;
					FN_MUL:  inst = MUL;
					FN_AND:  inst = AND;
					FN_OR:   inst = OR;
					FN_XOR:  inst = XOR;
					FN_SHR:  inst = SHR;
					FN_SHL:  inst = SHL;
					default: inst = UNKNOWN;
				endcase
			end
			OPC_ADDI: inst = ADDI;
			OPC_ANDI: inst = ANDI;
			OPC_ORI:  inst = ORI;
			OPC_XORI: inst = XORI;
			OPC_LW:   inst = LW;
			OPC_LWS:  inst = LWS;
			OPC_SW:   inst = SW;
			OPC_SWS:  inst = SWS;
			OPC_BEQ:  inst = BEQ;
			OPC_BLT:  inst = BLT;
			OPC_JMP:  inst = JMP;
			OPC_NOOP: inst = NOOP;
			// No scalar form of these three
			OPC_CALL: inst = scalar ? UNKNOWN : CALL;
			OPC_RET:  inst = scalar ? UNKNOWN : RET;
			OPC_EXIT: inst = scalar ? UNKNOWN : EXIT;
			default:  inst = UNKNOWN;
		endcase
	end

	always_comb begin
		case (inst)
			ADD, SUB, MUL, AND, OR, XOR, SHR, SHL:      fmt = FMT_R;
			ADDI, ANDI, ORI, XORI, LW, LWS, SW, SWS:    fmt = FMT_IMM;
			BEQ, BLT:                                   fmt = FMT_BR;
			JMP:                                        fmt = FMT_JMP;
			CALL:                                       fmt = FMT_CALL;
			RET, EXIT, NOOP:                            fmt = FMT_BARE;
			default:                                    fmt = FMT_UNK;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else
			dec_valid <= issue_valid;
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			dec <= '{inst: inst, fmt: fmt, scalar: scalar,
				rs: issue.instr[25:21], rt: issue.instr[20:16], rd: issue.instr[15:11],
				imm: issue.instr[15:0], jaddr: issue.instr[25:0],
				pc: issue.pc, warp_id: warp_bin};
		end
	end

	// Issue stage sends exactly one warp bit per transfer
	a_warp_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		issue_valid |-> $onehot(issue.warp_onehot));

endmodule

//--- design/render_fsm.sv
`timescale 1ns/1ns

module render_fsm (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 not_empty,
	input  trace_pkg::decoded_t                  head,
	output logic                                 pop,
	output logic                                 conv_start,
	output logic [trace_pkg::NUM_WIDTH-1:0]      conv_value,
	input  logic                                 conv_done,
	output trace_pkg::decoded_t                  rec,
	input  logic [8*trace_pkg::TEXT_CHARS-1:0]   text,
	input  logic                                 available,
	output logic                                 spend,
	output logic                                 trace_valid,
	output trace_pkg::trace_t                    trace
);
	import trace_pkg::*;

	render_state_e state;
	render_state_e state_next;
	logic          needs_conv;
	logic [15:0]   imm_mag;

	// Only formats that print a number go through the converter
	assign needs_conv = (rec.fmt == FMT_IMM) || (rec.fmt == FMT_BR) ||
		(rec.fmt == FMT_CALL) || (rec.fmt == FMT_JMP);

	// Sign is printed separately, convert the magnitude
	assign imm_mag    = rec.imm[15] ? (~rec.imm + 16'd1) : rec.imm;
	assign conv_value = (rec.fmt == FMT_JMP) ? rec.jaddr :
		{{(NUM_WIDTH-16){1'b0}}, imm_mag};

	assign pop         = (state == IDLE) && not_empty;
	assign conv_start  = (state == LOAD) && needs_conv;
	assign spend       = (state == SEND) && available;
	assign trace_valid = spend;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (not_empty)
					state_next = LOAD;
			end
			LOAD:    state_next = needs_conv ? CONVERT : FORMAT;
			CONVERT: begin
				if (conv_done)
					state_next = FORMAT;
			end
			FORMAT:  state_next = SEND;
			// Hold the record until the sink has room
			SEND: begin
				if (available)
					state_next = IDLE;
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge clk) begin
		if (pop)
			rec <= head;
		if (state == FORMAT) begin
			trace.text    <= text;
			trace.warp_id <= rec.warp_id;
			trace.pc      <= rec.pc;
			trace.imm     <= rec.imm;
			trace.jaddr   <= rec.jaddr;
		end
	end

endmodule

//--- design/text_formatter.sv
`timescale 1ns/1ns

module text_formatter (
	input  trace_pkg::decoded_t                  rec,
	input  logic [4*trace_pkg::NUM_DIGITS-1:0]   digits,
	output logic [8*trace_pkg::TEXT_CHARS-1:0]   text
);
	import trace_pkg::*;

	localparam int TOP    = 8*TEXT_CHARS - 1;
	localparam int HEAD_W = 8*(MNEM_CHARS + SUFFIX_CHARS);

	logic [8*MNEM_CHARS-1:0]   mnem;
	logic [8*SUFFIX_CHARS-1:0] suffix;
	logic [8*REG_CHARS-1:0]    rs_str;
	logic [8*REG_CHARS-1:0]    rt_str;
	logic [8*REG_CHARS-1:0]    rd_str;
	logic [8*IMM_CHARS-1:0]    imm_str;
	logic [8*JADDR_CHARS-1:0]  jaddr_str;

	// $0..$8 and $16 are the named registers of the core
	function automatic logic [8*REG_CHARS-1:0] reg_name(input logic [4:0] r);
		if (r <= 5'd8)
			return {" $", 8'h30 + {3'b000, r}, " "};
		else if (r == 5'd16)
			return " $16";
		else
			return " UNK";
	endfunction

	assign rs_str = reg_name(rec.rs);
	assign rt_str = reg_name(rec.rt);
	assign rd_str = reg_name(rec.rd);
	assign suffix = rec.scalar ? ".S" : "  ";

	always_comb begin
		imm_str[8*IMM_CHARS-1 -: 8] = rec.imm[15] ? "-" : "+";
		for (int i = 0; i < IMM_CHARS - 1; i++)
			imm_str[8*i +: 8] = {4'h3, digits[4*i +: 4]};
		for (int i = 0; i < JADDR_CHARS; i++)
			jaddr_str[8*i +: 8] = {4'h3, digits[4*i +: 4]};
	end

	always_comb begin
		case (rec.inst)
			ADD:  mnem = "ADD ";
			SUB:  mnem = "SUB ";
			MUL:  mnem = "MUL ";
			AND:  mnem = "AND ";
			OR:   mnem = "OR  ";
			XOR:  mnem = "XOR ";
			SHR:  mnem = "SHR ";
			SHL:  mnem = "SHL ";
			ADDI: mnem = "ADDI";
			ANDI: mnem = "ANDI";
			ORI:  mnem = "ORI ";
			XORI: mnem = "XORI";
			LW:   mnem = "LW  ";
			LWS:  mnem = "LWS ";
			SW:   mnem = "SW  ";
			SWS:  mnem = "SWS ";
			BEQ:  mnem = "BEQ ";
			BLT:  mnem = "BLT ";
			JMP:  mnem = "JMP ";
			CALL: mnem = "CALL";
			RET:  mnem = "RET ";
			EXIT: mnem = "EXIT";
			NOOP: mnem = "NOOP";
			default: mnem = "    ";
		endcase
	end

	////////////////////////////////////////////////////////////
	// Left-aligned layout, space padded
	////////////////////////////////////////////////////////////

	always_comb begin
		text = {TEXT_CHARS{8'h20}};
		case (rec.fmt)
			FMT_R:    text[TOP -: HEAD_W + 24*REG_CHARS] = {mnem, suffix, rd_str, rs_str, rt_str};
			FMT_IMM:  text[TOP -: HEAD_W + 16*REG_CHARS + 8*IMM_CHARS] =
				{mnem, suffix, rt_str, rs_str, imm_str};
			FMT_BR:   text[TOP -: HEAD_W + 16*REG_CHARS + 8*IMM_CHARS] =
				{mnem, suffix, rs_str, rt_str, imm_str};
			FMT_JMP:  text[TOP -: HEAD_W + 8*JADDR_CHARS] = {mnem, suffix, jaddr_str};
			// No suffix field on CALL and the bare forms
			FMT_CALL: text[TOP -: 8*(MNEM_CHARS + IMM_CHARS)] = {mnem, imm_str};
			FMT_BARE: text[TOP -: 8*MNEM_CHARS] = mnem;
			default:  text[TOP -: 56] = "Unknown";
		endcase
	end

endmodule

//--- design/trace_fifo.sv
`timescale 1ns/1ns

module trace_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                push,
	input  trace_pkg::decoded_t push_data,
	input  logic                pop,
	output trace_pkg::decoded_t head,
	output logic                not_empty,
	output logic                issue_credit
);
	import trace_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	decoded_t         mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Wrap for any depth, not only powers of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			issue_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Slot freed, one credit back upstream
			issue_credit <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	assign head      = mem[rd_ptr];
	assign not_empty = (count != '0);

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> (count != CNT_W'(FIFO_DEPTH)));
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> not_empty);

endmodule

//--- design/trace_pkg.sv
package trace_pkg;

	////////////////////////////////////////////////////////////
	// Text layout
	////////////////////////////////////////////////////////////

	localparam int TEXT_CHARS   = 20;
	localparam int NUM_WIDTH    = 26;
	localparam int NUM_DIGITS   = 8;
	localparam int MNEM_CHARS   = 4;
	localparam int SUFFIX_CHARS = 2;
	localparam int REG_CHARS    = 4;
	localparam int IMM_CHARS    = 6;
	localparam int JADDR_CHARS  = 8;

	////////////////////////////////////////////////////////////
	// Instruction set
	////////////////////////////////////////////////////////////

	// Primary opcodes, bit 30 (.S) cleared
	typedef enum logic [5:0] {
		OPC_RTYPE = 6'b000000, OPC_NOOP = 6'b000001, OPC_JMP  = 6'b000010,
		OPC_CALL  = 6'b000011, OPC_BEQ  = 6'b000100, OPC_RET  = 6'b000110,
		OPC_BLT   = 6'b000111, OPC_ADDI = 6'b001000, OPC_ANDI = 6'b001100,
		OPC_ORI   = 6'b001101, OPC_XORI = 6'b001110, OPC_EXIT = 6'b100001,
		OPC_LW    = 6'b100011, OPC_LWS  = 6'b100111, OPC_SW   = 6'b101011,
		OPC_SWS   = 6'b101111
	} opcode_e;

	// R-type function codes
	typedef enum logic [5:0] {
		FN_SHL = 6'b000000, FN_SHR = 6'b000010, FN_MUL = 6'b011000,
		FN_ADD = 6'b100000, FN_SUB = 6'b100010, FN_AND = 6'b100100,
		FN_OR  = 6'b100101, FN_XOR = 6'b100110
	} funct_e;

	typedef enum logic [4:0] {
		ADD, SUB, MUL, AND, OR, XOR, SHR, SHL,
		ADDI, ANDI, ORI, XORI, LW, LWS, SW, SWS,
		BEQ, BLT, JMP, CALL, RET, EXIT, NOOP, UNKNOWN
	} inst_e;

	typedef enum logic [2:0] {
		FMT_R, FMT_IMM, FMT_BR, FMT_JMP, FMT_CALL, FMT_BARE, FMT_UNK
	} fmt_e;

	typedef enum logic [2:0] {IDLE, LOAD, CONVERT, FORMAT, SEND} render_state_e;

	////////////////////////////////////////////////////////////
	// Records
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [7:0]  warp_onehot;
	} issue_t;

	typedef struct packed {
		inst_e       inst;
		fmt_e        fmt;
		logic        scalar;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		logic [25:0] jaddr;
		logic [31:0] pc;
		logic [2:0]  warp_id;
	} decoded_t;

	// First character sits in the top byte of text
	typedef struct packed {
		logic [8*TEXT_CHARS-1:0] text;
		logic [2:0]              warp_id;
		logic [31:0]             pc;
		logic [15:0]             imm;
		logic [25:0]             jaddr;
	} trace_t;

endpackage

//--- design/trace_render_top.sv
`timescale 1ns/1ns

module trace_render_top #(
	parameter int FIFO_DEPTH  = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              issue_valid,
	input  trace_pkg::issue_t issue,
	output logic              issue_credit,
	input  logic              trace_credit,
	output logic              trace_valid,
	output trace_pkg::trace_t trace
);
	import trace_pkg::*;

	logic                    dec_valid;
	decoded_t                dec;
	decoded_t                head;
	decoded_t                rec;
	logic                    not_empty;
	logic                    pop;
	logic                    conv_start;
	logic [NUM_WIDTH-1:0]    conv_value;
	logic                    conv_done;
	logic [4*NUM_DIGITS-1:0] digits;
	logic [8*TEXT_CHARS-1:0] text;
	logic                    available;
	logic                    spend;

	issue_decoder u_decoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue       (issue),
		.dec_valid   (dec_valid),
		.dec         (dec)
	);

	trace_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk          (clk),
		.rst_n        (rst_n),
		.push         (dec_valid),
		.push_data    (dec),
		.pop          (pop),
		.head         (head),
		.not_empty    (not_empty),
		.issue_credit (issue_credit)
	);

	bcd_converter u_bcd (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (conv_start),
		.value  (conv_value),
		.done   (conv_done),
		.digits (digits)
	);

	credit_counter #(.OUT_CREDITS(OUT_CREDITS)) u_credits (
		.clk       (clk),
		.rst_n     (rst_n),
		.grant     (trace_credit),
		.spend     (spend),
		.available (available)
	);

	render_fsm u_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.not_empty   (not_empty),
		.head        (head),
		.pop         (pop),
		.conv_start  (conv_start),
		.conv_value  (conv_value),
		.conv_done   (conv_done),
		.rec         (rec),
		.text        (text),
		.available   (available),
		.spend       (spend),
		.trace_valid (trace_valid),
		.trace       (trace)
	);

	// Formats the record held by the FSM
	text_formatter u_fmt (
		.rec    (rec),
		.digits (digits),
		.text   (text)
	);

endmodule

//--- dv/trace_vectors.svh
`ifndef TRACE_VECTORS_SVH
`define TRACE_VECTORS_SVH

// Columns are name, instruction word, PC, one-hot warp ID and expected text.
// Trailing spaces of the text are added by add_vector
task automatic load_vectors();
	// R-type: rd rs rt
	add_vector("add",        rtype_word('h00, 1, 2, 3, 'h20),  32'h0000_1000, 8'h01, "ADD    $3  $1  $2");
	add_vector("sub_s",      rtype_word('h10, 4, 5, 0, 'h22),  32'h0000_1004, 8'h02, "SUB .S $0  $4  $5");
	add_vector("mul",        rtype_word('h00, 7, 8, 6, 'h18),  32'h0000_1008, 8'h04, "MUL    $6  $7  $8");
	add_vector("and_s",      rtype_word('h10, 12, 0, 16, 'h24), 32'h0000_100c, 8'h08, "AND .S $16 UNK $0");
	add_vector("or",         rtype_word('h00, 2, 3, 1, 'h25),  32'h0000_1010, 8'h10, "OR     $1  $2  $3");
	add_vector("xor_s",      rtype_word('h10, 16, 7, 5, 'h26), 32'h0000_1014, 8'h20, "XOR .S $5  $16 $7");
	add_vector("shr",        rtype_word('h00, 8, 4, 2, 'h02),  32'h0000_1018, 8'h40, "SHR    $2  $8  $4");
	add_vector("shl_s",      rtype_word('h10, 3, 6, 12, 'h00), 32'h0000_101c, 8'h80, "SHL .S UNK $3  $6");
	add_vector("bad_funct",  rtype_word('h00, 1, 1, 1, 'h01),  32'h0000_1020, 8'h01, "Unknown");

	// Immediate forms: rt rs imm
	add_vector("addi",       itype_word('h08, 1, 2, 'h0000),   32'h0000_2000, 8'h02, "ADDI   $2  $1 +00000");
	add_vector("andi_s",     itype_word('h1c, 3, 4, 'h0001),   32'h0000_2004, 8'h04, "ANDI.S $4  $3 +00001");
	add_vector("ori",        itype_word('h0d, 5, 6, 'h7fff),   32'h0000_2008, 8'h08, "ORI    $6  $5 +32767");
	add_vector("xori",       itype_word('h0e, 7, 8, 'hffff),   32'h0000_200c, 8'h10, "XORI   $8  $7 -00001");
	add_vector("lw",         itype_word('h23, 16, 0, 'h8000),  32'h0000_2010, 8'h20, "LW     $0  $16-32768");
	add_vector("lws",        itype_word('h27, 1, 12, 'h0001),  32'h0000_2014, 8'h40, "LWS    UNK $1 +00001");
	add_vector("sw_s",       itype_word('h3b, 2, 3, 'h7fff),   32'h0000_2018, 8'h80, "SW  .S $3  $2 +32767");
	add_vector("sws",        itype_word('h2f, 4, 5, 'h8000),   32'h0000_201c, 8'h01, "SWS    $5  $4 -32768");

	// Branches: rs rt imm
	add_vector("beq",        itype_word('h04, 1, 2, 'hffff),   32'h0000_3000, 8'h02, "BEQ    $1  $2 -00001");
	add_vector("blt_s",      itype_word('h17, 3, 16, 'h0001),  32'h0000_3004, 8'h04, "BLT .S $3  $16+00001");

	// Jumps, calls and bare forms
	add_vector("jmp_zero",   jtype_word('h02, 'h0000000),      32'h0000_4000, 8'h08, "JMP   00000000");
	add_vector("jmp_max",    jtype_word('h02, 'h3ffffff),      32'hffff_fffc, 8'h10, "JMP   67108863");
	add_vector("call",       itype_word('h03, 0, 0, 'h8000),   32'h0000_4008, 8'h20, "CALL-32768");
	add_vector("call_s",     jtype_word('h13, 'h0000005),      32'h0000_400c, 8'h40, "Unknown");
	add_vector("ret",        jtype_word('h06, 'h0000000),      32'h0000_4010, 8'h80, "RET");
	add_vector("exit",       jtype_word('h21, 'h0000000),      32'h0000_4014, 8'h01, "EXIT");
	add_vector("noop",       jtype_word('h01, 'h0000000),      32'h0000_4018, 8'h02, "NOOP");
	add_vector("bad_opcode", jtype_word('h05, 'h0000123),      32'h8000_0000, 8'h04, "Unknown");
endtask

`endif

//--- dv/tb_trace_render.sv
`timescale 1ns/1ns

module tb_trace_render;
	import trace_pkg::*;

	localparam int FIFO_DEPTH  = 4;
	localparam int OUT_CREDITS = 2;
	localparam int TIMEOUT     = 200;

	logic   clk;
	logic   rst_n;
	logic   issue_valid;
	issue_t issue;
	logic   issue_credit;
	logic   trace_credit;
	logic   trace_valid;
	trace_t trace;

	// Vector table, filled by load_vectors
	string                   names[$];
	logic [31:0]             words[$];
	logic [31:0]             pcs[$];
	logic [7:0]              warps[$];
	logic [8*TEXT_CHARS-1:0] texts[$];

	int rx_idx        = 0;
	int returned      = 0;
	int credit_pulses = 0;

	trace_render_top #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue_valid  (issue_valid),
		.issue        (issue),
		.issue_credit (issue_credit),
		.trace_credit (trace_credit),
		.trace_valid  (trace_valid),
		.trace        (trace)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Table helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] rtype_word(input int op, input int rs, input int rt,
		input int rd, input int fn);
		return {op[5:0], rs[4:0], rt[4:0], rd[4:0], 5'd0, fn[5:0]};
	endfunction

	function automatic logic [31:0] itype_word(input int op, input int rs, input int rt,
		input int imm);
		return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] jtype_word(input int op, input int addr);
		return {op[5:0], addr[25:0]};
	endfunction

	// Left-aligned, space padded to the full text width
	function automatic logic [8*TEXT_CHARS-1:0] pad_text(input string s);
		logic [8*TEXT_CHARS-1:0] t;
		t = {TEXT_CHARS{8'h20}};
		for (int i = 0; i < s.len() && i < TEXT_CHARS; i++)
			t[8*(TEXT_CHARS-1-i) +: 8] = s[i];
		return t;
	endfunction

	task automatic add_vector(input string name, input logic [31:0] word,
		input logic [31:0] pc, input logic [7:0] warp, input string text);
		names.push_back(name);
		words.push_back(word);
		pcs.push_back(pc);
		warps.push_back(warp);
		texts.push_back(pad_text(text));
	endtask

	`include "trace_vectors.svh"

	function automatic logic [2:0] onehot_index(input logic [7:0] oh);
		logic [2:0] idx;
		idx = '0;
		for (int b = 0; b < 8; b++)
			if (oh[b])
				idx = 3'(b);
		return idx;
	endfunction

	function automatic trace_t expected_trace(input int i);
		trace_t t;
		t.text    = texts[i];
		t.warp_id = onehot_index(warps[i]);
		t.pc      = pcs[i];
		t.imm     = words[i][15:0];
		t.jaddr   = words[i][25:0];
		return t;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_trace(input string name, input trace_t exp, input trace_t act);
		if (act !== exp)
			abort_run({$sformatf("Mismatch %s: expected \"%s\" warp %0d pc %h imm %h jaddr %h,",
				name, exp.text, exp.warp_id, exp.pc, exp.imm, exp.jaddr),
				$sformatf(" actual \"%s\" warp %0d pc %h imm %h jaddr %h",
				act.text, act.warp_id, act.pc, act.imm, act.jaddr)});
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
			abort_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
	endtask

	// Upstream credits seen over the whole run
	always @(negedge clk) begin
		if (rst_n && issue_credit)
			credit_pulses++;
	end

	// Sink: checks records in order, returns each credit 0 to 7 cycles later
	initial begin
		int          credit_delay[$];
		logic [31:0] rng;
		rng          = 32'h98b0;
		trace_credit = 1'b0;
		forever begin
			@(negedge clk);
			trace_credit = 1'b0;
			foreach (credit_delay[i])
				if (credit_delay[i] > 0)
					credit_delay[i]--;
			if (credit_delay.size() > 0 && credit_delay[0] == 0) begin
				void'(credit_delay.pop_front());
				trace_credit = 1'b1;
				returned++;
			end
			if (trace_valid && rst_n) begin
				if (rx_idx >= names.size())
					abort_run("Record received after the last table entry");
				check_trace(names[rx_idx], expected_trace(rx_idx), trace);
				rx_idx++;
				if (rx_idx - returned > OUT_CREDITS)
					abort_run($sformatf("Sink overrun with %0d records outstanding",
						rx_idx - returned));
				rng = xorshift32(rng);
				credit_delay.push_back(int'(rng[2:0]));
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Driver and test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int idx;
		int idle;
		int credits_up;
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		issue       = '0;
		load_vectors();

		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			if (trace_valid !== 1'b0 || issue_credit !== 1'b0)
				abort_run("trace_valid or issue_credit was not low during reset");
		end
		rst_n = 1'b1;

		// Issue back to back while upstream credits last
		idx        = 0;
		idle       = 0;
		credits_up = FIFO_DEPTH;
		while (idx < names.size() || credits_up < FIFO_DEPTH) begin
			@(negedge clk);
			issue_valid = 1'b0;
			if (issue_credit) begin
				credits_up++;
				idle = 0;
			end
			if (idx < names.size() && credits_up > 0) begin
				issue_valid       = 1'b1;
				issue.instr       = words[idx];
				issue.pc          = pcs[idx];
				issue.warp_onehot = warps[idx];
				credits_up--;
				idx++;
				idle = 0;
			end else begin
				idle++;
			end
			if (idle > TIMEOUT)
				abort_run("Timeout waiting for an upstream credit");
		end

		idle = 0;
		while (rx_idx < names.size() || returned < rx_idx) begin
			@(posedge clk);
			idle++;
			if (idle > TIMEOUT)
				abort_run("Timeout waiting for trace records and sink credits");
		end

		check_count("issue_credit pulses", idx, credit_pulses);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- trace_render.f
+incdir+dv
design/trace_pkg.sv
design/issue_decoder.sv
design/trace_fifo.sv
design/bcd_converter.sv
design/credit_counter.sv
design/render_fsm.sv
design/text_formatter.sv
design/trace_render_top.sv
dv/tb_trace_render.sv
